// File: credit_fifo.sv
`timescale 1ns/1ns

module credit_fifo #(
	parameter type payload_t = logic,
	parameter int depth = yaw_pkg::link_credits
) (
	input  logic us_clk,
	input  logic resetn,
	input  logic wr,
	input  payload_t wr_data,
	input  logic rd,
	output payload_t rd_data,
	output logic empty,
	output logic credit
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic full;

	function automatic logic [ptr_w-1:0] ptr_inc(logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign full    = (count == cnt_w'(depth));
	assign rd_data = mem[rd_ptr];    // head of buffer, read without a cycle

	always_ff @(posedge us_clk) begin
		if (wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			credit <= rd;    // one credit back per pop
			if (wr)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd)
				rd_ptr <= ptr_inc(rd_ptr);
			if (wr && !rd)
				count <= count + 1'b1;
			else if (rd && !wr)
				count <= count - 1'b1;
		end
	end

	// a sender that counts its credits right never writes into a full buffer
	a_no_overflow: assert property (@(posedge us_clk) disable iff (!resetn) wr |-> !full);

endmodule

// File: flist.f
yaw_pkg.sv
yaw_link_if.sv
credit_fifo.sv
yaw_heading_tracker.sv
yaw_error_unwrap.sv
yaw_rate_shaper.sv
yaw_control_pipe.sv
tb_clock_gen.sv
tb_yaw_control_pipe.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_yaw_control_pipe -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -qxF "=== PASS ==="; then
	exit 0
fi
exit 1

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int period = 40,
	parameter int reset_cycles = 8
) (
	output logic us_clk,
	output logic resetn
);

	initial begin
		us_clk = 1'b0;
		forever #(period / 2) us_clk = ~us_clk;
	end

	initial begin
		resetn = 1'b0;
		repeat (reset_cycles) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;    // release away from the active edge
	end

endmodule

// File: tb_yaw_control_pipe.sv
`timescale 1ns/1ns

module tb_yaw_control_pipe;

	logic us_clk, resetn, in_valid, in_credit, out_valid, out_credit;
	logic [yaw_pkg::rec_w-1:0] throttle, yaw_stick;
	logic signed [yaw_pkg::angle_w-1:0] imu_yaw, body_yaw_angle, yaw_angle_error, yaw_rate_cmd;

	logic [yaw_pkg::rec_w-1:0] stim_thr[$], stim_stick[$];
	yaw_pkg::angle_t stim_imu[$];
	int exp_body[$], exp_err[$], exp_rate[$];
	int n_lines = 0;
	int sent = 0;        // samples handed to the DUT
	int returned = 0;    // in_credit pulses seen
	int received = 0;    // out_valid samples seen
	int given = 0;       // out_credit pulses handed back
	int errors = 0;

	tb_clock_gen clock_i (.us_clk, .resetn);

	yaw_control_pipe yaw_control_pipe_i (.*);

	task automatic check_value(int actual, int expected, string what);
		if (actual != expected) begin
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic load_stimulus(output bit ok);
		int fd;
		string line;
		logic [yaw_pkg::rec_w-1:0] t, s;
		yaw_pkg::angle_t y;
		int b, e, r;
		fd = $fopen("yaw_stim.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// comment and blank lines fail the six-field match
				if (line.len() > 0 && line.getc(0) != "#" &&
						$sscanf(line, "%d %d %d %d %d %d", t, s, y, b, e, r) == 6) begin
					stim_thr.push_back(t);
					stim_stick.push_back(s);
					stim_imu.push_back(y);
					exp_body.push_back(b);
					exp_err.push_back(e);
					exp_rate.push_back(r);
				end
			end
			$fclose(fd);
			n_lines = stim_thr.size();
		end
	endtask

	task automatic check_output();
		string tag;
		if (exp_body.size() == 0) begin
			$display("DUT gave an output at %0t with no sample left to match", $time);
			errors++;
		end else begin
			tag = $sformatf("sample %0d", received);
			check_value(int'(body_yaw_angle), exp_body.pop_front(), {tag, " body_yaw_angle"});
			check_value(int'(yaw_angle_error), exp_err.pop_front(), {tag, " yaw_angle_error"});
			check_value(int'(yaw_rate_cmd), exp_rate.pop_front(), {tag, " yaw_rate_cmd"});
			received++;
		end
	endtask

	// source side, never more than link_credits sends unanswered
	initial begin
		int gap;
		in_valid = 1'b0;
		throttle = '0;
		yaw_stick = '0;
		imu_yaw = '0;
		@(posedge resetn);
		gap = 3;    // quiet window after reset
		forever begin
			@(posedge us_clk);
			in_valid <= 1'b0;
			if (gap > 0)
				gap--;
			else if (sent < n_lines && sent - returned < yaw_pkg::link_credits) begin
				in_valid  <= 1'b1;
				throttle  <= stim_thr[sent];
				yaw_stick <= stim_stick[sent];
				imu_yaw   <= stim_imu[sent];
				sent++;
				gap = $urandom_range(3, 0);
			end
		end
	end

	// consumer holds each credit a little to make back-pressure
	initial begin
		int hold;
		out_credit = 1'b0;
		hold = 0;
		@(posedge resetn);
		forever begin
			@(posedge us_clk);
			out_credit <= 1'b0;
			if (hold > 0)
				hold--;
			else if (received > given) begin
				out_credit <= 1'b1;
				given++;
				hold = $urandom_range(5, 0);
			end
		end
	end

	always @(negedge us_clk) begin
		if (resetn) begin
			if (in_credit)
				returned++;
			if (returned > sent) begin
				$display("DUT returned more input credits than samples sent, at %0t", $time);
				errors++;
			end
			if (sent == 0) begin
				check_value(int'(in_credit), 0, "in_credit before stimulus");
				check_value(int'(out_valid), 0, "out_valid before stimulus");
			end
			if (out_valid) begin
				if (received - given >= yaw_pkg::link_credits) begin
					$display("DUT sent an output with no out_credit left, at %0t", $time);
					errors++;
				end
				check_output();
			end
		end
	end

	initial begin
		bit file_ok;
		bit timed_out;
		int cycles;
		int limit;
		void'($urandom(32'h2a75_e877));
		load_stimulus(file_ok);
		if (!file_ok)
			$display("cannot open yaw_stim.txt");
		limit = 40 * n_lines + 100;
		cycles = 0;
		while (received < n_lines && cycles < limit) begin
			@(posedge us_clk);
			cycles++;
		end
		timed_out = (received < n_lines);
		if (timed_out)
			$display("timeout after %0d cycles, only %0d of %0d samples came out", cycles, received,
				n_lines);
		repeat (4) @(posedge us_clk);    // catch any extra output
		$display("errors: %0d, samples: %0d of %0d", errors, received, n_lines);
		if (errors == 0 && file_ok && !timed_out && n_lines > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: yaw_control_pipe.sv
`timescale 1ns/1ns

module yaw_control_pipe (
	input  logic us_clk,
	input  logic resetn,
	input  logic in_valid,
	input  logic [yaw_pkg::rec_w-1:0] throttle,
	input  logic [yaw_pkg::rec_w-1:0] yaw_stick,
	input  logic signed [yaw_pkg::angle_w-1:0] imu_yaw,
	output logic in_credit,
	output logic out_valid,
	output logic signed [yaw_pkg::angle_w-1:0] body_yaw_angle,
	output logic signed [yaw_pkg::angle_w-1:0] yaw_angle_error,
	output logic signed [yaw_pkg::angle_w-1:0] yaw_rate_cmd,
	input  logic out_credit
);

	yaw_pkg::yaw_sample_t in_sample;

	yaw_link_if #(.payload_t(yaw_pkg::yaw_heading_t)) link_a ();    // tracker to error stage
	yaw_link_if #(.payload_t(yaw_pkg::yaw_error_t)) link_b ();      // error stage to shaper

	assign in_sample = '{throttle: throttle, stick: yaw_stick, imu_yaw: imu_yaw};

	yaw_heading_tracker tracker_i (
		.us_clk,
		.resetn,
		.in_valid,
		.in_sample,
		.in_credit,
		.out(link_a.sender)
	);

	yaw_error_unwrap unwrap_i (
		.us_clk,
		.resetn,
		.in(link_a.receiver),
		.out(link_b.sender)
	);

	yaw_rate_shaper shaper_i (
		.us_clk,
		.resetn,
		.in(link_b.receiver),
		.out_valid,
		.body_yaw_angle,
		.yaw_angle_error,
		.yaw_rate_cmd,
		.out_credit
	);

endmodule

// File: yaw_error_unwrap.sv
`timescale 1ns/1ns

module yaw_error_unwrap (
	input  logic us_clk,
	input  logic resetn,
	yaw_link_if.receiver in,
	yaw_link_if.sender out
);

	yaw_pkg::yaw_heading_t hd;
	logic fifo_empty;
	logic pop;
	yaw_pkg::credit_t credits;
	yaw_pkg::angle_t err;

	credit_fifo #(
		.payload_t(yaw_pkg::yaw_heading_t),
		.depth(yaw_pkg::link_credits)
	) in_fifo (
		.us_clk,
		.resetn,
		.wr(in.valid),
		.wr_data(in.payload),
		.rd(pop),
		.rd_data(hd),
		.empty(fifo_empty),
		.credit(in.credit)
	);

	assign pop = !fifo_empty && (credits != '0);

	// shortest signed error, taking the 0/360 seam into account
	always_comb begin
		if (hd.idle)
			err = '0;
		else if ((hd.body_yaw > yaw_pkg::angle_270) && (hd.imu_yaw < yaw_pkg::angle_90))
			err = yaw_pkg::angle_t'(hd.body_yaw - yaw_pkg::angle_360 - hd.imu_yaw);
		else if ((hd.imu_yaw > yaw_pkg::angle_270) && (hd.body_yaw < yaw_pkg::angle_90))
			err = yaw_pkg::angle_t'(yaw_pkg::angle_360 - hd.imu_yaw + hd.body_yaw);
		else
			err = yaw_pkg::angle_t'(hd.body_yaw - hd.imu_yaw);
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			credits   <= yaw_pkg::credit_t'(yaw_pkg::link_credits);
			out.valid <= 1'b0;
		end else begin
			credits   <= yaw_pkg::credit_next(credits, pop, out.credit);
			out.valid <= pop;
		end
	end

	always_ff @(posedge us_clk) begin
		if (pop)
			out.payload <= '{body_yaw: hd.body_yaw, yaw_error: err};
	end

endmodule

// File: yaw_heading_tracker.sv
`timescale 1ns/1ns

module yaw_heading_tracker (
	input  logic us_clk,
	input  logic resetn,
	input  logic in_valid,
	input  yaw_pkg::yaw_sample_t in_sample,
	output logic in_credit,
	yaw_link_if.sender out
);

	yaw_pkg::yaw_sample_t smp;
	logic fifo_empty;
	logic pop;
	logic idle;
	yaw_pkg::credit_t credits;

	yaw_pkg::track_t heading;    // target heading, quarter units
	yaw_pkg::track_t step;
	yaw_pkg::track_t moved;
	yaw_pkg::track_t wrapped;
	yaw_pkg::angle_t body_yaw;

	credit_fifo #(
		.payload_t(yaw_pkg::yaw_sample_t),
		.depth(yaw_pkg::link_credits)
	) in_fifo (
		.us_clk,
		.resetn,
		.wr(in_valid),
		.wr_data(in_sample),
		.rd(pop),
		.rd_data(smp),
		.empty(fifo_empty),
		.credit(in_credit)
	);

	assign pop  = !fifo_empty && (credits != '0);
	assign idle = smp.throttle < yaw_pkg::throttle_idle;

	// stick offset from center turns the heading
	assign step  = yaw_pkg::track_t'(smp.stick) - yaw_pkg::stick_center;
	assign moved = heading + step;

	always_comb begin
		if (moved >= yaw_pkg::track_360)
			wrapped = moved - yaw_pkg::track_360;    // past 360
		else if (moved < 0)
			wrapped = moved + yaw_pkg::track_360;    // below 0
		else
			wrapped = moved;
	end

	assign body_yaw = idle ? smp.imu_yaw : yaw_pkg::angle_t'(wrapped >>> 2);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			heading   <= '0;
			credits   <= yaw_pkg::credit_t'(yaw_pkg::link_credits);
			out.valid <= 1'b0;
		end else begin
			credits   <= yaw_pkg::credit_next(credits, pop, out.credit);
			out.valid <= pop;
			if (pop) begin
				if (idle)
					heading <= yaw_pkg::track_t'(smp.imu_yaw) * 4;    // resync to the IMU
				else
					heading <= wrapped;
			end
		end
	end

	always_ff @(posedge us_clk) begin
		if (pop)
			out.payload <= '{body_yaw: body_yaw, imu_yaw: smp.imu_yaw, idle: idle};
	end

	a_heading_range: assert property (@(posedge us_clk) disable iff (!resetn)
		pop |=> (heading >= 0) && (heading < yaw_pkg::track_360));

endmodule

// File: yaw_link_if.sv
`timescale 1ns/1ns

// credit flow link between two pipeline stages
interface yaw_link_if #(
	parameter type payload_t = logic
);

	logic valid;        // one cycle per sample
	payload_t payload;
	logic credit;       // one pulse per entry popped at the receiver

	modport sender (
		output valid,
		output payload,
		input  credit
	);

	modport receiver (
		input  valid,
		input  payload,
		output credit
	);

endinterface

// File: yaw_pkg.sv
package yaw_pkg;

	localparam int rec_w   = 8;     // receiver values
	localparam int angle_w = 16;    // angle, error and rate values
	localparam int track_w = 32;

	// angles in 1/16 degree
	localparam int angle_360 = 5760;
	localparam int angle_270 = 4320;
	localparam int angle_90  = 1440;
	localparam int track_360 = 23040;    // 360 degrees in quarter units

	localparam int stick_center  = 125;
	localparam int throttle_idle = 10;

	localparam int link_credits = 2;    // buffer depth and initial sender credits
	localparam int credit_w     = $clog2(link_credits + 1);

	localparam int rate_shift = 2;
	localparam int rate_limit = 250;

	typedef logic signed [angle_w-1:0] angle_t;
	typedef logic signed [track_w-1:0] track_t;
	typedef logic [credit_w-1:0] credit_t;

	typedef struct packed {
		logic [rec_w-1:0] throttle;
		logic [rec_w-1:0] stick;
		angle_t imu_yaw;
	} yaw_sample_t;

	typedef struct packed {
		angle_t body_yaw;
		angle_t imu_yaw;
		logic idle;
	} yaw_heading_t;

	typedef struct packed {
		angle_t body_yaw;
		angle_t yaw_error;
	} yaw_error_t;

	// a send costs one credit, a returned pulse gives one back
	function automatic credit_t credit_next(credit_t cnt, logic take, logic give);
		case ({take, give})
			2'b10: return cnt - 1'b1;
			2'b01: return cnt + 1'b1;
			default: return cnt;
		endcase
	endfunction

endpackage

// File: yaw_rate_shaper.sv
`timescale 1ns/1ns

module yaw_rate_shaper (
	input  logic us_clk,
	input  logic resetn,
	yaw_link_if.receiver in,
	output logic out_valid,
	output logic signed [yaw_pkg::angle_w-1:0] body_yaw_angle,
	output logic signed [yaw_pkg::angle_w-1:0] yaw_angle_error,
	output logic signed [yaw_pkg::angle_w-1:0] yaw_rate_cmd,
	input  logic out_credit
);

	yaw_pkg::yaw_error_t er;
	logic fifo_empty;
	logic pop;
	yaw_pkg::credit_t credits;    // toward the consumer
	yaw_pkg::angle_t shifted;
	yaw_pkg::angle_t rate;

	credit_fifo #(
		.payload_t(yaw_pkg::yaw_error_t),
		.depth(yaw_pkg::link_credits)
	) in_fifo (
		.us_clk,
		.resetn,
		.wr(in.valid),
		.wr_data(in.payload),
		.rd(pop),
		.rd_data(er),
		.empty(fifo_empty),
		.credit(in.credit)
	);

	assign pop     = !fifo_empty && (credits != '0);
	assign shifted = er.yaw_error >>> yaw_pkg::rate_shift;    // proportional gain

	always_comb begin
		if (shifted > yaw_pkg::rate_limit)
			rate = yaw_pkg::angle_t'(yaw_pkg::rate_limit);
		else if (shifted < -yaw_pkg::rate_limit)
			rate = yaw_pkg::angle_t'(-yaw_pkg::rate_limit);
		else
			rate = shifted;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			credits   <= yaw_pkg::credit_t'(yaw_pkg::link_credits);
			out_valid <= 1'b0;
		end else begin
			credits   <= yaw_pkg::credit_next(credits, pop, out_credit);
			out_valid <= pop;
		end
	end

	always_ff @(posedge us_clk) begin
		if (pop) begin
			body_yaw_angle  <= er.body_yaw;
			yaw_angle_error <= er.yaw_error;
			yaw_rate_cmd    <= rate;
		end
	end

	// bounded, and on the same side of zero as the error
	a_rate_limit: assert property (@(posedge us_clk) disable iff (!resetn)
		out_valid |-> (yaw_rate_cmd <= yaw_pkg::rate_limit) &&
		(yaw_rate_cmd >= -yaw_pkg::rate_limit) &&
		((yaw_rate_cmd < 0) == (yaw_angle_error < 0)));

endmodule

// File: yaw_stim.txt
# throttle stick imu_yaw | expected body_yaw_angle yaw_angle_error yaw_rate_cmd
# angles in 1/16 degree, throttle below 10 is idle
0 125 100 100 0 0
50 225 100 125 25 6
50 25 200 100 -100 -25
50 125 3000 100 -2900 -250
50 125 50 100 50 12
5 200 10 10 0 0
80 25 20 5745 -35 -9
80 125 5700 5745 45 11
80 255 5750 17 27 6
10 200 30 36 6 1
80 125 5000 36 796 199
80 125 4400 36 1396 250
9 125 3000 3000 0 0
200 130 1500 3001 1501 250
200 120 2980 3000 20 5
200 0 3100 2968 -132 -33
0 125 5000 5000 0 0
100 125 100 5000 -860 -215
100 125 1000 5000 -1760 -250
100 250 4900 5031 131 32
